//--- logic/pixel_pkg.sv
/*
 Pixel data formats for the YUV 4:2:2 to RGB 4:4:4 pipe
 Sample and sum types, and the pair structs passed between stages
*/
package pixel_pkg;

	typedef logic [7:0] sample_t;			// One Y, U, V or colour value
	typedef logic signed [31:0] matrix_sum_t;	// Colour sum before scaling

	// Input pair as it arrives from the source
	typedef struct packed {
		sample_t y_even;
		sample_t y_odd;
		sample_t u;
		sample_t v;
	} yuv_pair_t;

	typedef struct packed {
		sample_t y_even;
		sample_t y_odd;
		sample_t u_even;
		sample_t v_even;
		sample_t u_odd;		// Interpolated
		sample_t v_odd;		// Interpolated
	} upsampled_pair_t;

	typedef struct packed {
		matrix_sum_t r;
		matrix_sum_t g;
		matrix_sum_t b;
	} matrix_pixel_t;

	typedef struct packed {
		matrix_pixel_t even;
		matrix_pixel_t odd;
	} matrix_pair_t;

	typedef struct packed {
		sample_t r_even;
		sample_t g_even;
		sample_t b_even;
		sample_t r_odd;
		sample_t g_odd;
		sample_t b_odd;
	} rgb_pair_t;

endpackage

//--- logic/coeff_pkg.sv
/*
 Arithmetic constants for chroma interpolation and colour conversion
 Filter taps, matrix coefficients, offsets, row length and widths
*/
package coeff_pkg;

	typedef logic [8:0] tap_t;
	typedef logic [17:0] csc_coeff_t;

	localparam tap_t TAP_OUTER = 9'd21;
	localparam tap_t TAP_MIDDLE = 9'd52;	// Applied with a minus sign
	localparam tap_t TAP_INNER = 9'd159;
	localparam int FILTER_ROUND = 128;
	localparam int FILTER_SHIFT = 8;
	localparam int FILTER_W = 20;		// Holds 180 * 510 plus rounding, signed
	typedef logic signed [FILTER_W-1:0] filter_acc_t;

	localparam csc_coeff_t CSC_Y = 18'd76284;
	localparam csc_coeff_t CSC_RV = 18'd104595;
	localparam csc_coeff_t CSC_GU = 18'd25624;
	localparam csc_coeff_t CSC_GV = 18'd53281;
	localparam csc_coeff_t CSC_BU = 18'd132251;
	localparam int Y_OFFSET = 16;
	localparam int CHROMA_OFFSET = 128;
	localparam int CSC_SHIFT = 16;
	localparam int CSC_OPERAND_W = 10;	// Offset sample, -128..239
	typedef logic signed [CSC_OPERAND_W-1:0] csc_operand_t;

	localparam int PAIRS_PER_ROW = 160;
	localparam int ROW_CNT_W = $clog2(PAIRS_PER_ROW);
	typedef logic [ROW_CNT_W-1:0] row_count_t;
	localparam int FLUSH_CYCLES = 3;	// Also the filter lookahead in pairs

endpackage

//--- logic/chroma_upsample.sv
/*
 Decode stage: U and V windows with row-edge clamping,
 a four-entry Y queue and six-tap interpolation of the odd chroma
*/
module chroma_upsample (
	input  logic                       CLOCK_50_I,
	input  logic                       resetn,
	input  logic                       in_strobe,
	input  pixel_pkg::yuv_pair_t       in_pair,
	input  logic                       row_last,
	output logic                       up_strobe,
	output pixel_pkg::upsampled_pair_t up_pair
);
	import pixel_pkg::*;
	import coeff_pkg::*;

	typedef sample_t [5:0] chroma_window_t;	// Index 5 is the newest sample
	typedef logic [$clog2(FLUSH_CYCLES+1)-1:0] flush_count_t;

	chroma_window_t u_win;
	chroma_window_t v_win;
	sample_t [3:0] y_even_q;		// Index 0 is the pair being emitted
	sample_t [3:0] y_odd_q;
	sample_t y_even_in;
	sample_t y_odd_in;
	row_count_t row_cnt;
	flush_count_t flush_cnt;
	logic flushing;
	logic shift_en;
	logic row_start;

	assign flushing = (flush_cnt != '0);
	assign shift_en = in_strobe | flushing;
	assign row_start = in_strobe & (row_cnt == '0);
	assign y_even_in = in_strobe ? in_pair.y_even : y_even_q[3];	// Filler while flushing
	assign y_odd_in = in_strobe ? in_pair.y_odd : y_odd_q[3];

	// 21, -52, 159, 159, -52, 21 around the gap between taps 2 and 3
	function automatic sample_t interpolate(input chroma_window_t w);
		filter_acc_t outer_sum;
		filter_acc_t middle_sum;
		filter_acc_t inner_sum;
		filter_acc_t acc;
		outer_sum = filter_acc_t'({1'b0, w[0]}) + filter_acc_t'({1'b0, w[5]});
		middle_sum = filter_acc_t'({1'b0, w[1]}) + filter_acc_t'({1'b0, w[4]});
		inner_sum = filter_acc_t'({1'b0, w[2]}) + filter_acc_t'({1'b0, w[3]});
		acc = filter_acc_t'(TAP_OUTER) * outer_sum
			- filter_acc_t'(TAP_MIDDLE) * middle_sum
			+ filter_acc_t'(TAP_INNER) * inner_sum
			+ filter_acc_t'(FILTER_ROUND);
		acc = acc >>> FILTER_SHIFT;
		if (acc < 0)
			return '0;
		if (acc > 255)
			return '1;
		return sample_t'(acc);
	endfunction

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			row_cnt <= '0;
			flush_cnt <= '0;
			up_strobe <= 1'b0;
		end else begin
			// Pair k leaves once pair k+3 is in the window
			up_strobe <= (in_strobe & (row_cnt >= row_count_t'(FLUSH_CYCLES))) | flushing;
			if (in_strobe && row_last) begin
				row_cnt <= '0;
				flush_cnt <= flush_count_t'(FLUSH_CYCLES);	// Drain the last three pairs
			end else begin
				if (in_strobe)
					row_cnt <= row_cnt + 1'b1;
				if (flushing)
					flush_cnt <= flush_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (row_start) begin
			u_win <= {6{in_pair.u}};	// Left edge repeats the first sample
			v_win <= {6{in_pair.v}};
		end else if (in_strobe) begin
			u_win <= {in_pair.u, u_win[5:1]};
			v_win <= {in_pair.v, v_win[5:1]};
		end else if (flushing) begin
			u_win <= {u_win[5], u_win[5:1]};	// Right edge repeats the last sample
			v_win <= {v_win[5], v_win[5:1]};
		end
		if (shift_en) begin
			y_even_q <= {y_even_in, y_even_q[3:1]};
			y_odd_q <= {y_odd_in, y_odd_q[3:1]};
		end
	end

	always_comb begin
		up_pair.y_even = y_even_q[0];
		up_pair.y_odd = y_odd_q[0];
		up_pair.u_even = u_win[2];	// Co-sited sample
		up_pair.v_even = v_win[2];
		up_pair.u_odd = interpolate(u_win);
		up_pair.v_odd = interpolate(v_win);
	end

endmodule

//--- logic/colour_matrix.sv
/*
 Execute stage: offset removal and signed colour-matrix sums
 for R, G and B of both pixels of a pair
*/
module colour_matrix (
	input  logic                       CLOCK_50_I,
	input  logic                       resetn,
	input  logic                       up_strobe,
	input  pixel_pkg::upsampled_pair_t up_pair,
	output logic                       sum_strobe,
	output pixel_pkg::matrix_pair_t    sum_pair
);
	import pixel_pkg::*;
	import coeff_pkg::*;

	// Sample minus its offset, as a small signed operand
	function automatic csc_operand_t centre(input sample_t s, input int offset);
		return csc_operand_t'({2'b00, s}) - csc_operand_t'(offset);
	endfunction

	function automatic matrix_sum_t csc_term(input csc_coeff_t coeff,
			input csc_operand_t operand);
		matrix_sum_t coeff_s;
		matrix_sum_t operand_s;
		coeff_s = matrix_sum_t'({1'b0, coeff});	// Coefficients are positive
		operand_s = matrix_sum_t'(operand);
		return coeff_s * operand_s;
	endfunction

	function automatic matrix_pixel_t pixel_sums(input sample_t y, input sample_t u,
			input sample_t v);
		matrix_pixel_t px;
		matrix_sum_t luma;
		csc_operand_t u_c;
		csc_operand_t v_c;
		luma = csc_term(CSC_Y, centre(y, Y_OFFSET));	// Shared by all three channels
		u_c = centre(u, CHROMA_OFFSET);
		v_c = centre(v, CHROMA_OFFSET);
		px.r = luma + csc_term(CSC_RV, v_c);
		px.g = luma - csc_term(CSC_GU, u_c) - csc_term(CSC_GV, v_c);
		px.b = luma + csc_term(CSC_BU, u_c);
		return px;
	endfunction

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn)
			sum_strobe <= 1'b0;
		else
			sum_strobe <= up_strobe;
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (up_strobe) begin
			sum_pair.even <= pixel_sums(up_pair.y_even, up_pair.u_even, up_pair.v_even);
			sum_pair.odd <= pixel_sums(up_pair.y_odd, up_pair.u_odd, up_pair.v_odd);
		end
	end

endmodule

//--- logic/rgb_clip.sv
/*
 Result stage: scales the matrix sums and clips them to 8-bit RGB
*/
module rgb_clip (
	input  logic                    CLOCK_50_I,
	input  logic                    resetn,
	input  logic                    sum_strobe,
	input  pixel_pkg::matrix_pair_t sum_pair,
	output logic                    out_strobe,
	output pixel_pkg::rgb_pair_t    out_pair
);
	import pixel_pkg::*;
	import coeff_pkg::*;

	function automatic sample_t clip_sum(input matrix_sum_t sum);
		matrix_sum_t scaled;
		scaled = sum >>> CSC_SHIFT;	// Drop the 16 fraction bits
		if (scaled < 0)
			return '0;
		if (scaled > 255)
			return '1;
		return sample_t'(scaled);
	endfunction

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn)
			out_strobe <= 1'b0;
		else
			out_strobe <= sum_strobe;
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (sum_strobe) begin
			out_pair.r_even <= clip_sum(sum_pair.even.r);
			out_pair.g_even <= clip_sum(sum_pair.even.g);
			out_pair.b_even <= clip_sum(sum_pair.even.b);
			out_pair.r_odd <= clip_sum(sum_pair.odd.r);
			out_pair.g_odd <= clip_sum(sum_pair.odd.g);
			out_pair.b_odd <= clip_sum(sum_pair.odd.b);
		end
	end

endmodule

//--- logic/yuv_rgb_top.sv
/*
 Top level of the YUV 4:2:2 to RGB 4:4:4 pipe
 Decode, execute and result stages in a row
*/
module yuv_rgb_top (
	input  logic                 CLOCK_50_I,
	input  logic                 resetn,
	input  logic                 in_strobe,
	input  pixel_pkg::yuv_pair_t in_pair,
	input  logic                 row_last,
	output logic                 out_strobe,
	output pixel_pkg::rgb_pair_t out_pair
);
	import pixel_pkg::*;

	logic up_strobe;
	upsampled_pair_t up_pair;
	logic sum_strobe;
	matrix_pair_t sum_pair;

	chroma_upsample u_chroma_upsample (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.in_strobe  (in_strobe),
		.in_pair    (in_pair),
		.row_last   (row_last),
		.up_strobe  (up_strobe),
		.up_pair    (up_pair)
	);

	colour_matrix u_colour_matrix (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.up_strobe  (up_strobe),
		.up_pair    (up_pair),
		.sum_strobe (sum_strobe),
		.sum_pair   (sum_pair)
	);

	rgb_clip u_rgb_clip (
		.CLOCK_50_I (CLOCK_50_I),
		.resetn     (resetn),
		.sum_strobe (sum_strobe),
		.sum_pair   (sum_pair),
		.out_strobe (out_strobe),
		.out_pair   (out_pair)
	);

endmodule

//--- sim/yuv_rgb_props.sv
/*
 Concurrent assertions on the top-level strobes, bound to yuv_rgb_top
*/
module yuv_rgb_props (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_strobe,
	input logic row_last,
	input logic up_strobe,
	input logic sum_strobe,
	input logic out_strobe
);
	import coeff_pkg::*;

	int fail_cnt = 0;	// Assertion failures so far

	a_reset_quiet: assert property (@(posedge CLOCK_50_I)
		!resetn |-> !(up_strobe | sum_strobe | out_strobe))
		else begin
			$error("Strobe high while reset is asserted");
			fail_cnt++;
		end

	a_sum_follows: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		sum_strobe == $past(up_strobe))
		else begin
			$error("sum_strobe does not follow up_strobe by one cycle");
			fail_cnt++;
		end

	a_out_follows: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		out_strobe == $past(sum_strobe))
		else begin
			$error("out_strobe does not follow sum_strobe by one cycle");
			fail_cnt++;
		end

	a_flush_gap: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		(in_strobe && row_last) |=> !in_strobe [*FLUSH_CYCLES])
		else begin
			$error("Input strobe inside the flush gap after row_last");
			fail_cnt++;
		end

endmodule

bind yuv_rgb_top yuv_rgb_props props (.*);

//--- sim/tb_yuv_rgb.sv
/*
 Testbench for yuv_rgb_top with clock, reset, LFSR stimulus,
 reference model, in-order compare and timeout
*/
module tb_yuv_rgb;
	import pixel_pkg::*;
	import coeff_pkg::*;

	localparam int NUM_TESTS = 4;
	localparam int TOTAL_ROWS = 6;
	localparam int TIMEOUT = TOTAL_ROWS * (PAIRS_PER_ROW + FLUSH_CYCLES) + 50;

	logic CLOCK_50_I = 1'b0;
	logic resetn = 1'b1;
	logic in_strobe;
	yuv_pair_t in_pair;
	logic row_last;
	logic out_strobe;
	rgb_pair_t out_pair;

	sample_t ye[PAIRS_PER_ROW];	// Current row
	sample_t yo[PAIRS_PER_ROW];
	sample_t us[PAIRS_PER_ROW];
	sample_t vs[PAIRS_PER_ROW];
	rgb_pair_t exp_q[$];
	int id_q[$];
	string names[NUM_TESTS] = '{"flat_grey", "random_rows", "edge_clamp", "saturation"};
	int test_left[NUM_TESTS];
	int test_err[NUM_TESTS];
	int errors = 0;
	int checked = 0;
	int cycles = 0;
	int prev_err;
	int cur_id;
	logic [31:0] lfsr = 32'h1c6b_e663;

	yuv_rgb_top dut (.*);

	initial begin
		forever #2 CLOCK_50_I = ~CLOCK_50_I;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function sample_t rand_byte();
		sample_t b;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0];
		end
		return b;
	endfunction

	function automatic sample_t clip8(input int x);
		return (x < 0) ? 8'd0 : (x > 255) ? 8'd255 : sample_t'(x);
	endfunction

	// Six-tap interpolation between samples k and k+1 with indices clamped to the row
	function automatic sample_t interp_ref(input sample_t c[PAIRS_PER_ROW], input int k);
		int idx[6];
		int t[6] = '{21, -52, 159, 159, -52, 21};
		int acc;
		acc = 128;
		for (int i = 0; i < 6; i++) begin
			idx[i] = k - 2 + i;
			if (idx[i] < 0) idx[i] = 0;
			if (idx[i] > PAIRS_PER_ROW - 1) idx[i] = PAIRS_PER_ROW - 1;
			acc += t[i] * int'(c[idx[i]]);
		end
		return clip8(acc >>> 8);
	endfunction

	function automatic logic [23:0] csc_ref(input sample_t y, input sample_t u, input sample_t v);
		int yc;
		int uc;
		int vc;
		yc = 76284 * (int'(y) - 16);
		uc = int'(u) - 128;
		vc = int'(v) - 128;
		return {clip8((yc + 104595 * vc) >>> 16),
			clip8((yc - 25624 * uc - 53281 * vc) >>> 16),
			clip8((yc + 132251 * uc) >>> 16)};
	endfunction

	function automatic rgb_pair_t ref_pair(input int k);
		return {csc_ref(ye[k], us[k], vs[k]),
			csc_ref(yo[k], interp_ref(us, k), interp_ref(vs, k))};
	endfunction

	task automatic check_pair(input string name, input rgb_pair_t exp, input rgb_pair_t act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic fill_row(input int id);
		for (int k = 0; k < PAIRS_PER_ROW; k++) begin
			case (id)
				0: begin
					ye[k] = 8'd128;
					yo[k] = 8'd128;
					us[k] = 8'd128;
					vs[k] = 8'd128;
				end
				3: begin	// Blocks of 40 pairs, one per extreme
					ye[k] = (k / 40 == 0 || k / 40 == 3) ? 8'd255 : 8'd0;
					yo[k] = ye[k];
					us[k] = (k / 40 < 3) ? ((k / 40 == 1) ? 8'd0 : 8'd255) : 8'd0;
					vs[k] = us[k];
				end
				default: begin
					ye[k] = rand_byte();
					yo[k] = rand_byte();
					us[k] = rand_byte();
					vs[k] = rand_byte();
				end
			endcase
		end
		if (id == 2) begin
			us[0] = 8'd10;
			vs[0] = 8'd240;
			us[PAIRS_PER_ROW-1] = 8'd250;
			vs[PAIRS_PER_ROW-1] = 8'd5;
		end
	endtask

	task automatic run_test(input int id, input int rows);
		test_left[id] = rows * PAIRS_PER_ROW;
		for (int r = 0; r < rows; r++) begin
			fill_row(id);
			for (int k = 0; k < PAIRS_PER_ROW; k++) begin
				exp_q.push_back(ref_pair(k));
				id_q.push_back(id);
			end
			for (int k = 0; k < PAIRS_PER_ROW; k++) begin
				@(negedge CLOCK_50_I);
				in_strobe = 1'b1;
				in_pair = '{ye[k], yo[k], us[k], vs[k]};
				row_last = (k == PAIRS_PER_ROW - 1);
			end
			@(negedge CLOCK_50_I);
			in_strobe = 1'b0;
			row_last = 1'b0;
			repeat (FLUSH_CYCLES - 1) @(negedge CLOCK_50_I);	// Flush gap
		end
	endtask

	// Outputs are stable on the falling edge
	always @(negedge CLOCK_50_I) begin
		if (out_strobe !== 1'b0) begin
			if (exp_q.size() == 0) begin
				$display("Output strobe seen with no pair pending (reset or idle)");
				errors++;
			end else begin
				cur_id = id_q.pop_front();
				prev_err = errors;
				check_pair(names[cur_id], exp_q.pop_front(), out_pair);
				if (errors != prev_err)
					test_err[cur_id]++;
				checked++;
				test_left[cur_id]--;
				if (test_left[cur_id] == 0)
					$display("Test %s done, %0d mismatches", names[cur_id], test_err[cur_id]);
			end
		end
	end

	always @(posedge CLOCK_50_I) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			$display("Timeout after %0d cycles with %0d pairs still pending", cycles, exp_q.size());
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		in_strobe = 1'b0;
		in_pair = '0;
		row_last = 1'b0;
		#1 resetn = 1'b0;	// Asserted before the first rising edge
		repeat (4) @(posedge CLOCK_50_I);
		@(negedge CLOCK_50_I);
		resetn = 1'b1;
		repeat (5) @(negedge CLOCK_50_I);	// Idle, no output expected
		$display("Test reset done, %0d mismatches", errors);
		run_test(0, 1);
		run_test(1, 3);
		run_test(2, 1);
		run_test(3, 1);
		while (exp_q.size() != 0)
			@(negedge CLOCK_50_I);
		repeat (4) @(negedge CLOCK_50_I);
		$display("Checked %0d pairs, %0d errors, %0d assertion failures", checked, errors,
			dut.props.fail_cnt);
		if (errors == 0 && dut.props.fail_cnt == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- yuv_rgb.f
logic/pixel_pkg.sv
logic/coeff_pkg.sv
logic/chroma_upsample.sv
logic/colour_matrix.sv
logic/rgb_clip.sv
logic/yuv_rgb_top.sv
sim/yuv_rgb_props.sv
sim/tb_yuv_rgb.sv

//--- Bender.yml
package:
  name: yuv_rgb

sources:
  - logic/pixel_pkg.sv
  - logic/coeff_pkg.sv
  - logic/chroma_upsample.sv
  - logic/colour_matrix.sv
  - logic/rgb_clip.sv
  - logic/yuv_rgb_top.sv
  - target: simulation
    files:
      - sim/yuv_rgb_props.sv
      - sim/tb_yuv_rgb.sv
